// ==== mem_interconnect.f ====
+incdir+src
src/ic_pkg.sv
src/mem_req_if.sv
src/addr_decoder.sv
src/load_aligner.sv
src/tohost_unit.sv
src/cons_rx_fifo.sv
src/mem_interconnect.sv
test/interconnect_chk.sv
test/tb_mem_interconnect.sv

// ==== src/addr_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// address decode: per-device strobes in the request cycle, and read-data
// select registered for the following cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ic_macros.svh"

module addr_decoder (
    input  logic        CLK,
    input  logic        i_rst,
    mem_req_if.device   req,
    input  logic        i_dram_busy,
    input  logic [31:0] i_load_word,
    input  logic [31:0] i_cons_rdata,
    input  logic [31:0] i_plic_rdata,
    input  logic [31:0] i_clint_rdata,
    input  logic [31:0] i_fb_rdata,
    output logic        o_dram_we,
    output logic        o_dram_le,
    output logic [31:0] o_dram_addr,
    output logic        o_plic_we,
    output logic        o_plic_re,
    output logic        o_clint_we,
    output logic        o_fb_we,
    output logic        o_cons_pop,
    output logic [31:0] o_data,
    output logic        o_is_dram
);
    logic [3:0]       dev;
    logic [3:0]       virt;
    logic             dram_ok;
    ic_pkg::dev_sel_t sel;
    ic_pkg::dev_sel_t r_sel;

    assign dev  = req.addr[31:28];
    assign virt = req.addr[27:24];

    always_comb begin
        case (dev)
            `IC_DEV_DRAM_LO, `IC_DEV_DRAM_HI: sel = ic_pkg::dev_dram;
            `IC_DEV_PLIC:                     sel = ic_pkg::dev_plic;
            `IC_DEV_CLINT:                    sel = ic_pkg::dev_clint;
            `IC_DEV_VIRTIO: begin
                if (virt == `IC_VIRT_CONS) begin
                    sel = ic_pkg::dev_cons;
                end else if (virt == `IC_VIRT_FB) begin
                    sel = ic_pkg::dev_fb;
                end else begin
                    sel = ic_pkg::dev_none;
                end
            end
            default:                          sel = ic_pkg::dev_none;
        endcase
    end

    // dram is only touched while the controller is idle
    assign dram_ok = (sel == ic_pkg::dev_dram) && !i_dram_busy;

    assign o_dram_we   = req.we && dram_ok;
    assign o_dram_le   = req.re && dram_ok;
    assign o_dram_addr = {5'b0, req.addr[26:0]};
    assign o_plic_we   = req.we && (sel == ic_pkg::dev_plic);
    assign o_plic_re   = req.re && (sel == ic_pkg::dev_plic);
    assign o_clint_we  = req.we && (sel == ic_pkg::dev_clint);
    assign o_fb_we     = req.we && (sel == ic_pkg::dev_fb);
    // a store to the console window consumes one byte
    assign o_cons_pop  = req.we && (sel == ic_pkg::dev_cons);

    // a stalled dram read returns nothing, the core retries it
    always_ff @(posedge CLK) begin
        if (i_rst) begin
            r_sel <= ic_pkg::dev_none;
        end else if (req.re && !(sel == ic_pkg::dev_dram && i_dram_busy)) begin
            r_sel <= sel;
        end else begin
            r_sel <= ic_pkg::dev_none;
        end
    end

    always_comb begin
        case (r_sel)
            ic_pkg::dev_dram:  o_data = i_load_word;
            ic_pkg::dev_cons:  o_data = i_cons_rdata;
            ic_pkg::dev_fb:    o_data = i_fb_rdata;
            ic_pkg::dev_plic:  o_data = i_plic_rdata;
            ic_pkg::dev_clint: o_data = i_clint_rdata;
            default:           o_data = 32'h0;
        endcase
    end

    assign o_is_dram = (r_sel == ic_pkg::dev_dram);
endmodule

// ==== src/cons_rx_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// console receive FIFO, filled by the serial receiver and read or popped
// by the core through the console window
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ic_macros.svh"

module cons_rx_fifo (
    input  logic        CLK,
    input  logic        i_rst,
    input  logic        i_push,
    input  logic [7:0]  i_push_data,
    input  logic        i_pop,
    output logic [31:0] o_head
);
    localparam int         ptr_w = $clog2(`IC_CONS_FIFO_DEPTH);
    localparam logic [ptr_w:0] full_cnt = `IC_CONS_FIFO_DEPTH;

    logic [7:0]     mem [`IC_CONS_FIFO_DEPTH];
    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [ptr_w:0]   count;
    logic             push_ok;
    logic             pop_ok;

    // bytes arriving on a full fifo are lost
    assign push_ok = i_push && (count != full_cnt);
    assign pop_ok  = i_pop && (count != '0);

    always_ff @(posedge CLK) begin
        if (i_rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push_ok) begin
                tail <= tail + 1'b1;
            end
            if (pop_ok) begin
                head <= head + 1'b1;
            end
            count <= count + push_ok - pop_ok;
        end
    end

    always_ff @(posedge CLK) begin
        if (push_ok) begin
            mem[tail] <= i_push_data;
        end
    end

    // head value of the request cycle, lined up with the registered select
    always_ff @(posedge CLK) begin
        if (i_rst || count == '0) begin
            o_head <= 32'h0;
        end else begin
            o_head <= {24'h0, mem[head]};
        end
    end
endmodule

// ==== src/ic_macros.svh ====
////////////////////////////////////////////////////////////////////////////
// memory interconnect constants: address map, tohost mailbox address,
// mailbox command codes and console FIFO depth
////////////////////////////////////////////////////////////////////////////
`ifndef IC_MACROS_SVH
`define IC_MACROS_SVH

// device field, addr[31:28]
`define IC_DEV_DRAM_LO      4'h0
`define IC_DEV_DRAM_HI      4'h8
`define IC_DEV_VIRTIO       4'h4
`define IC_DEV_PLIC         4'h5
`define IC_DEV_CLINT        4'h6

// virtio sub-field, addr[27:24]
`define IC_VIRT_CONS        4'h0
`define IC_VIRT_FB          4'h5

// mailbox sits outside every device window
`define IC_TOHOST_ADDR      32'h7000_0000

// command lives in the upper half of the tohost word
`define IC_CMD_PRINT_CHAR   16'h0001
`define IC_CMD_POWER_OFF    16'h0002

`define IC_CONS_FIFO_DEPTH  16

`endif

// ==== src/ic_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// interconnect types: device select, load control code, tohost command
////////////////////////////////////////////////////////////////////////////
package ic_pkg;

    // device picked by the address decode
    typedef enum logic [2:0] {
        dev_dram,
        dev_cons,
        dev_fb,
        dev_plic,
        dev_clint,
        dev_none
    } dev_sel_t;

    // load size encodings, same as funct3[1:0]
    localparam logic [1:0] ld_size_b = 2'd0;
    localparam logic [1:0] ld_size_h = 2'd1;
    localparam logic [1:0] ld_size_w = 2'd2;

    // funct3 of a load: unsigned flag on top, size below
    typedef struct packed {
        logic       uns;
        logic [1:0] size;
    } ld_ctrl_t;

    // command half of a tohost word
    typedef logic [15:0] tohost_cmd_t;

endpackage

// ==== src/load_aligner.sv ====
////////////////////////////////////////////////////////////////////////////
// load data extraction from the 128-bit dram line, with sign or zero
// extension of bytes and halfwords
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module load_aligner (
    input  logic         CLK,
    input  logic         i_rst,
    input  logic [31:0]  i_addr,
    input  logic [2:0]   i_ctrl,
    input  logic         i_capture,
    input  logic [127:0] i_line,
    output logic [31:0]  o_word
);
    logic [3:0]       r_offset;
    ic_pkg::ld_ctrl_t r_ctrl;
    logic [127:0]     shifted;
    logic [31:0]      raw;
    logic             sext;

    // line arrives the cycle after the access, so keep its offset and code
    always_ff @(posedge CLK) begin
        if (i_rst) begin
            r_offset <= 4'h0;
            r_ctrl   <= ic_pkg::ld_ctrl_t'(3'b0);
        end else if (i_capture) begin
            r_offset <= i_addr[3:0];
            r_ctrl   <= ic_pkg::ld_ctrl_t'(i_ctrl);
        end
    end

    assign shifted = i_line >> {r_offset, 3'b000};
    assign raw     = shifted[31:0];
    assign sext    = !r_ctrl.uns;

    always_comb begin
        case (r_ctrl.size)
            ic_pkg::ld_size_b: o_word = {{24{raw[7] & sext}}, raw[7:0]};
            ic_pkg::ld_size_h: o_word = {{16{raw[15] & sext}}, raw[15:0]};
            default:           o_word = raw;
        endcase
    end
endmodule

// ==== src/mem_interconnect.sv ====
////////////////////////////////////////////////////////////////////////////
// memory interconnect top that decodes core data requests onto dram, plic,
// clint, framebuffer, console fifo and tohost mailbox
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_interconnect (
    input  logic         CLK,
    input  logic         i_rst,
    // core data port
    input  logic [31:0]  i_data_addr,
    input  logic [31:0]  i_data_wdata,
    input  logic         i_data_we,
    input  logic         i_data_re,
    input  logic [2:0]   i_data_ctrl,
    output logic [31:0]  o_data,
    output logic         o_is_dram,
    // external dram
    input  logic [127:0] i_dram_line,
    input  logic         i_dram_busy,
    output logic [31:0]  o_dram_addr,
    output logic         o_dram_we,
    output logic         o_dram_le,
    output logic [31:0]  o_dram_wdata,
    output logic [2:0]   o_dram_ctrl,
    // mmio devices
    output logic         o_plic_we,
    output logic         o_plic_re,
    input  logic [31:0]  i_plic_rdata,
    output logic         o_clint_we,
    input  logic [31:0]  i_clint_rdata,
    output logic         o_fb_we,
    input  logic [31:0]  i_fb_rdata,
    output logic [31:0]  o_io_wdata,
    output logic [27:0]  o_offset,
    // serial console
    input  logic         i_rx_valid,
    input  logic [7:0]   i_rx_data,
    output logic         o_uart_we,
    output logic [7:0]   o_uart_data,
    input  logic         i_tx_ready,
    output logic         o_finish,
    output logic         o_proc_busy
);
    logic [31:0] load_word;
    logic [31:0] cons_rdata;
    logic        cons_pop;
    logic        proc_busy;

    mem_req_if req ();

    assign req.addr  = i_data_addr;
    assign req.wdata = i_data_wdata;
    assign req.we    = i_data_we;
    assign req.re    = i_data_re;
    assign req.ctrl  = ic_pkg::ld_ctrl_t'(i_data_ctrl);

    // stall while dram is working or the uart cannot take a byte
    assign proc_busy   = i_dram_busy || !i_tx_ready;
    assign o_proc_busy = proc_busy;

    assign o_dram_wdata = i_data_wdata;
    assign o_dram_ctrl  = i_data_ctrl;
    assign o_io_wdata   = i_data_wdata;
    assign o_offset     = i_data_addr[27:0];

    addr_decoder u_addr_decoder (
        .CLK           (CLK),
        .i_rst         (i_rst),
        .req           (req.device),
        .i_dram_busy   (i_dram_busy),
        .i_load_word   (load_word),
        .i_cons_rdata  (cons_rdata),
        .i_plic_rdata  (i_plic_rdata),
        .i_clint_rdata (i_clint_rdata),
        .i_fb_rdata    (i_fb_rdata),
        .o_dram_we     (o_dram_we),
        .o_dram_le     (o_dram_le),
        .o_dram_addr   (o_dram_addr),
        .o_plic_we     (o_plic_we),
        .o_plic_re     (o_plic_re),
        .o_clint_we    (o_clint_we),
        .o_fb_we       (o_fb_we),
        .o_cons_pop    (cons_pop),
        .o_data        (o_data),
        .o_is_dram     (o_is_dram)
    );

    load_aligner u_load_aligner (
        .CLK       (CLK),
        .i_rst     (i_rst),
        .i_addr    (i_data_addr),
        .i_ctrl    (req.ctrl),
        .i_capture (o_dram_le),
        .i_line    (i_dram_line),
        .o_word    (load_word)
    );

    tohost_unit u_tohost_unit (
        .CLK         (CLK),
        .i_rst       (i_rst),
        .req         (req.device),
        .i_hold      (proc_busy),
        .o_uart_we   (o_uart_we),
        .o_uart_data (o_uart_data),
        .o_finish    (o_finish)
    );

    cons_rx_fifo u_cons_rx_fifo (
        .CLK         (CLK),
        .i_rst       (i_rst),
        .i_push      (i_rx_valid),
        .i_push_data (i_rx_data),
        .i_pop       (cons_pop),
        .o_head      (cons_rdata)
    );
endmodule

// ==== src/mem_req_if.sv ====
////////////////////////////////////////////////////////////////////////////
// one data-side memory request as seen by the decoder and the devices
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface mem_req_if;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic             we;
    logic             re;
    ic_pkg::ld_ctrl_t ctrl;

    // core side
    modport driver (
        output addr, wdata, we, re, ctrl
    );

    // decoder, mailbox and fifo side
    modport device (
        input addr, wdata, we, re, ctrl
    );
endinterface

// ==== src/tohost_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// tohost mailbox: print-char commands become console bytes, power-off
// sets a sticky finish flag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ic_macros.svh"

module tohost_unit (
    input  logic       CLK,
    input  logic       i_rst,
    mem_req_if.device  req,
    input  logic       i_hold,
    output logic       o_uart_we,
    output logic [7:0] o_uart_data,
    output logic       o_finish
);
    logic [31:0]         mbox;
    ic_pkg::tohost_cmd_t cmd;
    logic                mbox_we;
    logic                print_go;

    assign cmd = mbox[31:16];

    // held request retries once busy drops
    assign mbox_we  = req.we && (req.addr == `IC_TOHOST_ADDR) && !i_hold;
    // tx not ready, keep the char pending
    assign print_go = (cmd == `IC_CMD_PRINT_CHAR) && !i_hold;

    always_ff @(posedge CLK) begin
        if (i_rst) begin
            mbox      <= 32'h0;
            o_uart_we <= 1'b0;
            o_finish  <= 1'b0;
        end else begin
            o_uart_we <= print_go;
            if (cmd == `IC_CMD_POWER_OFF) begin
                o_finish <= 1'b1;
            end
            // new command wins over clearing the old one
            if (mbox_we) begin
                mbox <= req.wdata;
            end else if (print_go || cmd == `IC_CMD_POWER_OFF) begin
                mbox <= 32'h0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (print_go) begin
            o_uart_data <= mbox[7:0];
        end
    end
endmodule

// ==== test/interconnect_chk.sv ====
////////////////////////////////////////////////////////////////////////////
// interconnect checker for decode strobes, tohost output timing and the
// busy rules
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ic_macros.svh"

module interconnect_chk (
    input logic        CLK,
    input logic        i_rst,
    input logic [31:0] i_data_addr,
    input logic [31:0] i_data_wdata,
    input logic        i_data_we,
    input logic        i_dram_busy,
    input logic        i_tx_ready,
    input logic        o_dram_we,
    input logic        o_dram_le,
    input logic        o_plic_we,
    input logic        o_plic_re,
    input logic        o_clint_we,
    input logic        o_fb_we,
    input logic        o_uart_we,
    input logic        o_finish,
    input logic        o_proc_busy
);
    int                  fail_cnt = 0;
    logic [3:0]          dev;
    ic_pkg::tohost_cmd_t wr_cmd;
    logic                wr_mbox;

    assign dev     = i_data_addr[31:28];
    assign wr_cmd  = i_data_wdata[31:16];
    assign wr_mbox = i_data_we && (i_data_addr == `IC_TOHOST_ADDR) && !o_proc_busy;

    a_one_strobe: assert property (@(posedge CLK) disable iff (i_rst)
        $onehot0({o_dram_we, o_dram_le, o_plic_we, o_plic_re, o_clint_we, o_fb_we}))
        else begin
            $error("more than one device strobe in a cycle");
            fail_cnt++;
        end

    a_dram_field: assert property (@(posedge CLK) disable iff (i_rst)
        (o_dram_we || o_dram_le) |-> (dev == `IC_DEV_DRAM_LO || dev == `IC_DEV_DRAM_HI))
        else begin
            $error("dram strobe outside the dram fields");
            fail_cnt++;
        end

    a_mmio_field: assert property (@(posedge CLK) disable iff (i_rst)
        ((o_plic_we || o_plic_re) |-> dev == `IC_DEV_PLIC) and
        (o_clint_we |-> dev == `IC_DEV_CLINT) and
        (o_fb_we |-> dev == `IC_DEV_VIRTIO && i_data_addr[27:24] == `IC_VIRT_FB))
        else begin
            $error("mmio strobe does not match the device field");
            fail_cnt++;
        end

    // busy controller never sees a strobe
    a_dram_busy: assert property (@(posedge CLK) disable iff (i_rst)
        i_dram_busy |-> !o_dram_we && !o_dram_le)
        else begin
            $error("dram strobe while the dram is busy");
            fail_cnt++;
        end

    a_proc_busy: assert property (@(posedge CLK) disable iff (i_rst)
        o_proc_busy == (i_dram_busy || !i_tx_ready))
        else begin
            $error("core busy does not follow dram busy and tx ready");
            fail_cnt++;
        end

    a_print_pulse: assert property (@(posedge CLK) disable iff (i_rst)
        wr_mbox && wr_cmd == `IC_CMD_PRINT_CHAR |-> ##2 o_uart_we ##1 !o_uart_we)
        else begin
            $error("print char did not give a one-cycle uart pulse two cycles later");
            fail_cnt++;
        end

    a_finish_delay: assert property (@(posedge CLK) disable iff (i_rst)
        $rose(o_finish) |-> $past(wr_mbox && wr_cmd == `IC_CMD_POWER_OFF, 2))
        else begin
            $error("finish rose without a power off two cycles earlier");
            fail_cnt++;
        end

    a_finish_sticky: assert property (@(posedge CLK) disable iff (i_rst)
        o_finish |=> o_finish)
        else begin
            $error("finish flag dropped before reset");
            fail_cnt++;
        end
endmodule

bind mem_interconnect interconnect_chk u_chk (.*);

// ==== test/tb_mem_interconnect.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the memory interconnect covering decode, load alignment,
// mmio, tohost mailbox, console fifo and back-pressure
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ic_macros.svh"

module tb_mem_interconnect;
    // rough cycle budget per test
    localparam int len_decode = 20;
    localparam int len_load   = 20;
    localparam int len_mmio   = 10;
    localparam int len_print  = 10;
    localparam int len_fifo   = 110;
    localparam int len_power  = 30;
    localparam int max_cycles = 2 * (len_decode + len_load + len_mmio + len_print
                                     + len_fifo + len_power);

    logic         CLK = 1'b0;
    logic         i_rst;
    logic [31:0]  i_data_addr, i_data_wdata;
    logic         i_data_we, i_data_re;
    logic [2:0]   i_data_ctrl;
    logic [31:0]  o_data;
    logic         o_is_dram;
    logic [127:0] i_dram_line;
    logic         i_dram_busy;
    logic [31:0]  o_dram_addr, o_dram_wdata;
    logic         o_dram_we, o_dram_le;
    logic [2:0]   o_dram_ctrl;
    logic         o_plic_we, o_plic_re, o_clint_we, o_fb_we;
    logic [31:0]  i_plic_rdata, i_clint_rdata, i_fb_rdata, o_io_wdata;
    logic [27:0]  o_offset;
    logic         i_rx_valid;
    logic [7:0]   i_rx_data, o_uart_data;
    logic         o_uart_we, i_tx_ready, o_finish, o_proc_busy;

    int          cycle_cnt = 0;
    int          test_errs = 0;
    int          chk_base = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cyc;
    string       test_name;
    logic [15:0] lfsr_state = 16'd9;
    logic [7:0]  sent [$];
    logic [5:0]  strobes;
    logic [31:0] data, addr, r;
    logic        isd;
    logic [31:0] dec_addr [9] = '{32'h0000_0100, 32'h8000_0200, 32'h4500_0010,
        32'h4000_0000, 32'h5000_0004, 32'h6000_4000, 32'h1000_0000, 32'h4300_0000,
        32'h7000_0000};
    logic [3:0]  ld_off [8] = '{4'd3, 4'd9, 4'd6, 4'd10, 4'd4, 4'd12, 4'd15, 4'd0};
    logic [2:0]  ld_code [8] = '{3'b000, 3'b100, 3'b001, 3'b101, 3'b010, 3'b010,
        3'b000, 3'b001};

    mem_interconnect u_mem_interconnect (.*);

    always #2 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // byte k of a line is k xor the low address byte of the line
    function automatic logic [127:0] model_line(input logic [31:0] a);
        logic [127:0] l;
        for (int k = 0; k < 16; k++) begin
            l[k*8 +: 8] = k[7:0] ^ {a[7:4], 4'h0};
        end
        return l;
    endfunction

    always @(posedge CLK) begin
        if (o_dram_le) begin
            i_dram_line <= #1 model_line(o_dram_addr);
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] a, input logic [2:0] c);
        logic [127:0]     l;
        logic [31:0]      w;
        ic_pkg::ld_ctrl_t code;
        l = model_line(a);
        w = l[a[3:0]*8 +: 32];
        code = ic_pkg::ld_ctrl_t'(c);
        case (code.size)
            ic_pkg::ld_size_b: return {{24{w[7] & !code.uns}}, w[7:0]};
            ic_pkg::ld_size_h: return {{16{w[15] & !code.uns}}, w[15:0]};
            default:           return w;
        endcase
    endfunction

    // {dram_we, dram_le, plic_we, plic_re, clint_we, fb_we}
    function automatic logic [5:0] expected_strobes(input logic [31:0] a, input logic we,
                                                    input logic re, input logic busy);
        logic [3:0] dev;
        logic       dram, plic, clint, fb;
        dev   = a[31:28];
        dram  = (dev == `IC_DEV_DRAM_LO || dev == `IC_DEV_DRAM_HI) && !busy;
        plic  = (dev == `IC_DEV_PLIC);
        clint = (dev == `IC_DEV_CLINT);
        fb    = (dev == `IC_DEV_VIRTIO) && (a[27:24] == `IC_VIRT_FB);
        return {we && dram, re && dram, we && plic, re && plic, we && clint, we && fb};
    endfunction

    task step_clock;
        @(posedge CLK);
        #1;
    endtask

    task check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s expected %h actual %h", test_name, name, exp, act);
            test_errs++;
        end
    endtask

    // strobes and pass-through ports sampled in the request cycle, read data in the next
    task do_access(input logic [31:0] a, input logic [31:0] wd, input logic [2:0] c,
                   input logic we, input logic re);
        step_clock();
        i_data_addr  = a;
        i_data_wdata = wd;
        i_data_ctrl  = c;
        i_data_we    = we;
        i_data_re    = re;
        #2;
        strobes = {o_dram_we, o_dram_le, o_plic_we, o_plic_re, o_clint_we, o_fb_we};
        check_value("dram addr", a & 32'h07ff_ffff, o_dram_addr);
        check_value("dram wdata", wd, o_dram_wdata);
        check_value("dram ctrl", {29'h0, c}, o_dram_ctrl);
        check_value("io wdata", wd, o_io_wdata);
        check_value("offset", {4'h0, a[27:0]}, o_offset);
        step_clock();
        i_data_we = 1'b0;
        i_data_re = 1'b0;
        #2;
        data = o_data;
        isd  = o_is_dram;
    endtask

    task push_bytes(input int n);
        for (int k = 0; k < n; k++) begin
            step_clock();
            i_rx_valid = 1'b1;
            i_rx_data  = 8'(rand_bits(8));
            sent.push_back(i_rx_data);
        end
        step_clock();
        i_rx_valid = 1'b0;
    endtask

    // read the head, compare, then pop it
    task drain_bytes(input string name, input int n);
        for (int k = 0; k < n; k++) begin
            do_access(32'h4000_0000, '0, 3'b010, 1'b0, 1'b1);
            check_value(name, {24'h0, sent[k]}, data);
            do_access(32'h4000_0000, '0, 3'b010, 1'b1, 1'b0);
        end
        do_access(32'h4000_0000, '0, 3'b010, 1'b0, 1'b1);
        check_value({name, " empty"}, 32'h0, data);
    endtask

    task wait_rise(input bit on_finish, output int n);
        n = 1;
        while (!(on_finish ? o_finish : o_uart_we) && n < 8) begin
            @(posedge CLK);
            #3;
            n++;
        end
    endtask

    task finish_test(input string name);
        int errs;
        errs = test_errs + (u_mem_interconnect.u_chk.fail_cnt - chk_base);
        if (errs == 0) begin
            $display("test %s: pass", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, errs);
            tests_failed++;
        end
        test_errs = 0;
        chk_base  = u_mem_interconnect.u_chk.fail_cnt;
    endtask

    initial begin
        i_rst = 1'b1;
        i_data_addr = '0;
        i_data_wdata = '0;
        i_data_we = 1'b0;
        i_data_re = 1'b0;
        i_data_ctrl = 3'b010;
        i_dram_line = '0;
        i_dram_busy = 1'b0;
        i_plic_rdata = '0;
        i_clint_rdata = '0;
        i_fb_rdata = '0;
        i_rx_valid = 1'b0;
        i_rx_data = '0;
        i_tx_ready = 1'b1;
        repeat (3) @(posedge CLK);
        #1;
        i_rst = 1'b0;

        test_name = "decode";
        foreach (dec_addr[k]) begin
            do_access(dec_addr[k], rand_bits(32), 3'b010, 1'b1, 1'b0);
            check_value("decode", expected_strobes(dec_addr[k], 1'b1, 1'b0, 1'b0), strobes);
        end
        do_access(32'h5000_0008, '0, 3'b010, 1'b0, 1'b1);
        check_value("decode read", expected_strobes(32'h5000_0008, 1'b0, 1'b1, 1'b0), strobes);
        finish_test(test_name);

        test_name = "load alignment";
        foreach (ld_off[k]) begin
            r = rand_bits(5);
            addr = {(r[4] ? `IC_DEV_DRAM_HI : `IC_DEV_DRAM_LO), 20'h01234, r[3:0], ld_off[k]};
            do_access(addr, '0, ld_code[k], 1'b0, 1'b1);
            check_value("load data", expected_load(addr, ld_code[k]), data);
            check_value("load is_dram", 32'h1, isd);
        end
        finish_test(test_name);

        test_name = "mmio read mux";
        step_clock();
        i_plic_rdata  = rand_bits(32);
        i_clint_rdata = rand_bits(32);
        i_fb_rdata    = rand_bits(32);
        do_access(32'h5000_0040, '0, 3'b010, 1'b0, 1'b1);
        check_value("plic read", i_plic_rdata, data);
        check_value("plic is_dram", 32'h0, isd);
        do_access(32'h6000_bff8, '0, 3'b010, 1'b0, 1'b1);
        check_value("clint read", i_clint_rdata, data);
        check_value("clint is_dram", 32'h0, isd);
        do_access(32'h4500_0100, '0, 3'b010, 1'b0, 1'b1);
        check_value("fb read", i_fb_rdata, data);
        check_value("fb is_dram", 32'h0, isd);
        finish_test(test_name);

        test_name = "print char";
        r = rand_bits(8);
        do_access(`IC_TOHOST_ADDR, {`IC_CMD_PRINT_CHAR, 8'h00, r[7:0]}, 3'b010, 1'b1, 1'b0);
        wait_rise(1'b0, cyc);
        check_value("print delay", 32'd2, cyc);
        check_value("print byte", {24'h0, r[7:0]}, {24'h0, o_uart_data});
        @(posedge CLK);
        #3;
        check_value("print pulse width", 32'h0, o_uart_we);
        finish_test(test_name);

        test_name = "console fifo";
        do_access(32'h4000_0000, '0, 3'b010, 1'b0, 1'b1);
        check_value("fifo empty", 32'h0, data);
        push_bytes(3);
        drain_bytes("fifo order", 3);
        sent.delete();
        push_bytes(17);
        drain_bytes("fifo full", 16);
        finish_test(test_name);

        test_name = "power off and busy";
        step_clock();
        i_dram_busy = 1'b1;
        do_access(32'h8000_0020, rand_bits(32), 3'b010, 1'b1, 1'b0);
        check_value("busy write", expected_strobes(32'h8000_0020, 1'b1, 1'b0, 1'b1), strobes);
        check_value("busy dram", 32'h1, o_proc_busy);
        do_access(32'h0000_0030, '0, 3'b010, 1'b0, 1'b1);
        check_value("busy read", expected_strobes(32'h0000_0030, 1'b0, 1'b1, 1'b1), strobes);
        step_clock();
        i_dram_busy = 1'b0;
        i_tx_ready  = 1'b0;
        #2;
        check_value("busy tx", 32'h1, o_proc_busy);
        step_clock();
        i_tx_ready = 1'b1;
        #2;
        check_value("busy idle", 32'h0, o_proc_busy);
        do_access(`IC_TOHOST_ADDR, {`IC_CMD_POWER_OFF, 16'h0}, 3'b010, 1'b1, 1'b0);
        wait_rise(1'b1, cyc);
        check_value("finish delay", 32'd2, cyc);
        repeat (3) @(posedge CLK);
        #3;
        check_value("finish sticky", 32'h1, o_finish);
        finish_test(test_name);

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && u_mem_interconnect.u_chk.fail_cnt == chk_base) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end
endmodule
